// File: compile.f
+incdir+sim
hdl/procPkg.sv
hdl/fetch.sv
hdl/control.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
sim/procTb.sv

// File: sim/procTests.svh
// Instruction encoders
function automatic logic [15:0] rType(input procPkg::aluOpT fn, input int rs, input int rt,
                                      input int rd);
   return {procPkg::opAlu, 3'(rs), 3'(rt), 3'(rd), fn};
endfunction

function automatic logic [15:0] iType(input procPkg::opcodeT op, input int rs, input int rd,
                                      input int imm);
   return {op, 3'(rs), 3'(rd), 5'(imm)};  // ADDI, SUBI, LD, ST
endfunction

function automatic logic [15:0] wideImm(input procPkg::opcodeT op, input int rs, input int imm);
   return {op, 3'(rs), 8'(imm)};  // LBI and branches
endfunction

function automatic logic [15:0] jDisp(input int disp);
   return {procPkg::opJ, 11'(disp)};
endfunction

function automatic logic [15:0] plainOp(input procPkg::opcodeT op);
   return {op, 11'd0};
endfunction

// Reference interpreter, fills expWrites with the writes the core should retire
task automatic predictWrites();
   logic [15:0] regs [8];
   logic [15:0] dmem [int];
   logic [15:0] pc;
   logic [15:0] ins;
   logic [15:0] s;
   logic [15:0] t;
   logic [15:0] res;
   logic [15:0] imm5;
   logic [15:0] imm8;
   logic [2:0]  dst;
   logic        wr;
   int          addr;
   foreach (regs[i]) regs[i] = '0;  // Register file clears on reset
   pc     = '0;
   expErr = 1'b0;
   expWrites.delete();
   for (int step = 0; step < maxSteps; step++) begin
      if (pc >= prog.size()) abortRun("Reference model ran past the end of the program");
      ins  = prog[pc];
      s    = regs[ins[10:8]];             // rs
      t    = regs[ins[7:5]];              // rt
      imm5 = {{11{ins[4]}}, ins[4:0]};
      imm8 = {{8{ins[7]}}, ins[7:0]};
      addr = int'((s + imm5) & 16'h00ff);  // 256 data words
      dst  = ins[7:5];
      wr   = 1'b0;
      pc   = pc + 16'd1;                  // Offsets are relative to PC+1
      case (ins[15:11])
         procPkg::opHalt: return;
         procPkg::opNop: wr = 1'b0;
         procPkg::opAlu: begin
            dst = ins[4:2];
            wr  = 1'b1;
            case (ins[1:0])
               procPkg::aluAdd: res = s + t;
               procPkg::aluSub: res = t - s;  // rt minus rs
               procPkg::aluAnd: res = s & t;
               default:         res = s ^ t;
            endcase
         end
         procPkg::opAddi: {wr, res} = {1'b1, s + imm5};
         procPkg::opSubi: {wr, res} = {1'b1, imm5 - s};  // Immediate minus rs
         procPkg::opLbi: begin
            dst = ins[10:8];  // LBI writes its rs field
            wr  = 1'b1;
            res = imm8;
         end
         procPkg::opLd: begin
            if (!dmem.exists(addr)) abortRun("Reference model loads an address never stored");
            wr  = 1'b1;
            res = dmem[addr];
         end
         procPkg::opSt: dmem[addr] = t;
         procPkg::opBeqz: if (s == '0) pc = pc + imm8;
         procPkg::opBnez: if (s != '0) pc = pc + imm8;
         procPkg::opJ: pc = pc + {{5{ins[10]}}, ins[10:0]};
         default: begin
            expErr = 1'b1;  // Trap, nothing retires after it
            return;
         end
      endcase
      if (wr) begin
         regs[dst] = res;
         expWrites.push_back({dst, res});
      end
   end
   abortRun("Reference model hit its step limit");
endtask

// Run the loaded program and follow the trace port every cycle until it stops
task automatic watchTrace(input string name, input bit poke, input logic [15:0] pokeAddr,
                          input logic [15:0] pokeData);
   writeT expected;
   predictWrites();
   run       <= 1'b1;
   loadValid <= poke;      // Load attempt while running
   loadAddr  <= pokeAddr;
   loadData  <= pokeData;
   @(negedge clk);
   while (!halt && !err) begin
      checkFlag("loadReady while running", loadReady, 1'b0);
      if (wbValid) begin
         if (expWrites.size() == 0)
            abortRun($sformatf("%s: extra register write to r%0d at %0t", name, wbReg, $time));
         expected = expWrites.pop_front();
         checkWrite(wbReg, wbData, expected, name);
      end
      @(negedge clk);
   end
   if (expWrites.size() != 0)
      abortRun($sformatf("%s: %0d expected register writes never appeared", name,
                         expWrites.size()));
   checkFlag("halt", halt, !expErr);
   checkFlag("err", err, expErr);
   repeat (tailCycles) begin
      checkFlag("wbValid after stop", wbValid, 1'b0);
      @(negedge clk);
   end
   @(posedge clk);
   run       <= 1'b0;
   loadValid <= 1'b0;
   @(posedge clk);
endtask

task automatic runProgram(input string name);
   resetDut();
   loadProgram();
   watchTrace(name, 1'b0, '0, '0);
endtask

task automatic regAluOps();
   prog.delete();
   for (int r = 1; r < 8; r++)
      prog.push_back(wideImm(procPkg::opLbi, r, $urandom));  // Random signed bytes
   prog.push_back(rType(procPkg::aluAdd, 1, 2, 3));
   prog.push_back(rType(procPkg::aluSub, 4, 5, 6));  // r6 = r5 - r4
   prog.push_back(rType(procPkg::aluAnd, 6, 7, 1));
   prog.push_back(rType(procPkg::aluXor, 3, 1, 2));
   prog.push_back(rType(procPkg::aluSub, 7, 2, 0));
   prog.push_back(rType(procPkg::aluAdd, 3, 3, 4));
   prog.push_back(plainOp(procPkg::opHalt));
   runProgram("register ALU");
endtask

task automatic immediateOps();
   prog.delete();
   prog.push_back(wideImm(procPkg::opLbi, 1, -100));
   prog.push_back(iType(procPkg::opAddi, 1, 2, -7));
   prog.push_back(iType(procPkg::opSubi, 2, 3, -16));
   prog.push_back(iType(procPkg::opAddi, 0, 4, 15));
   prog.push_back(iType(procPkg::opSubi, 4, 5, 3));
   prog.push_back(wideImm(procPkg::opLbi, 6, 127));
   prog.push_back(wideImm(procPkg::opLbi, 7, -128));
   prog.push_back(plainOp(procPkg::opHalt));
   runProgram("immediates");
endtask

task automatic memoryRoundTrip();
   prog.delete();
   prog.push_back(wideImm(procPkg::opLbi, 1, 40));  // Base address
   for (int k = 0; k < 4; k++) begin
      prog.push_back(wideImm(procPkg::opLbi, 2, $urandom));
      prog.push_back(iType(procPkg::opSt, 1, 2, k - 2));
   end
   prog.push_back(wideImm(procPkg::opLbi, 3, $urandom));
   prog.push_back(iType(procPkg::opSt, 1, 3, 1));   // Overwrite base+1
   for (int k = 0; k < 4; k++)
      prog.push_back(iType(procPkg::opLd, 1, 4 + k, k - 2));
   prog.push_back(plainOp(procPkg::opHalt));
   runProgram("memory");
endtask

task automatic branchAndJump();
   prog.delete();
   prog.push_back(wideImm(procPkg::opLbi, 1, 5));     // Loop count
   prog.push_back(wideImm(procPkg::opLbi, 2, 0));
   prog.push_back(iType(procPkg::opAddi, 2, 2, 3));
   prog.push_back(iType(procPkg::opAddi, 1, 1, -1));
   prog.push_back(wideImm(procPkg::opBnez, 1, -3));   // Back to the add
   prog.push_back(wideImm(procPkg::opBeqz, 1, 1));    // Taken
   prog.push_back(wideImm(procPkg::opLbi, 3, 99));    // Skipped
   prog.push_back(wideImm(procPkg::opBnez, 1, 1));    // Not taken
   prog.push_back(wideImm(procPkg::opBeqz, 2, 1));    // Not taken
   prog.push_back(wideImm(procPkg::opLbi, 4, 7));
   prog.push_back(jDisp(2));                          // Forward over two words
   prog.push_back(wideImm(procPkg::opLbi, 5, 1));
   prog.push_back(wideImm(procPkg::opLbi, 5, 2));
   prog.push_back(wideImm(procPkg::opLbi, 6, 3));
   prog.push_back(iType(procPkg::opAddi, 6, 6, -1));
   prog.push_back(wideImm(procPkg::opBeqz, 6, 1));
   prog.push_back(jDisp(-3));                         // Countdown loop
   prog.push_back(plainOp(procPkg::opHalt));
   runProgram("control flow");
endtask

task automatic haltAndTrap();
   prog.delete();
   prog.push_back(wideImm(procPkg::opLbi, 1, 1));
   prog.push_back(plainOp(procPkg::opHalt));
   prog.push_back(wideImm(procPkg::opLbi, 2, 2));  // Never retires
   prog.push_back(plainOp(procPkg::opHalt));
   runProgram("halt");
   prog.delete();
   prog.push_back(wideImm(procPkg::opLbi, 1, 4));
   prog.push_back(16'hf800);                       // Opcode 11111 is unassigned
   prog.push_back(wideImm(procPkg::opLbi, 2, 5));
   prog.push_back(plainOp(procPkg::opHalt));
   runProgram("illegal opcode");
endtask

task automatic loadPortGuard();
   prog.delete();
   prog.push_back(wideImm(procPkg::opLbi, 1, 11));
   prog.push_back(plainOp(procPkg::opNop));
   prog.push_back(plainOp(procPkg::opNop));
   prog.push_back(iType(procPkg::opAddi, 1, 2, 1));
   prog.push_back(plainOp(procPkg::opHalt));
   resetDut();
   loadProgram();
   loadAddr <= 16'd1;                           // Offered with valid low
   loadData <= wideImm(procPkg::opLbi, 3, 55);
   repeat (3) @(posedge clk);
   watchTrace("load port", 1'b1, 16'd3, wideImm(procPkg::opLbi, 2, 77));
endtask

// File: sim/procTb.sv
`timescale 1ns/1ns

module procTb;

   localparam int resetCycles   = 16;
   localparam int maxProgWords  = 32;    // Longest directed program
   localparam int maxSteps      = 400;   // Model step limit per program
   localparam int tailCycles    = 4;     // Quiet cycles watched after a stop
   localparam int numRuns       = 7;     // Programs executed over the whole run
   localparam int timeoutCycles = numRuns * (resetCycles + maxProgWords + maxSteps + tailCycles)
                                  + 800;  // Roughly 4000 cycles

   // One expected or observed register write
   typedef struct packed {
      logic [procPkg::regAddrWidth-1:0] r;
      logic [procPkg::dataWidth-1:0]    d;
   } writeT;

   logic                             clk;
   logic                             reset;
   logic                             run;
   logic                             loadValid;
   logic [procPkg::dataWidth-1:0]    loadAddr;
   logic [procPkg::dataWidth-1:0]    loadData;
   logic                             loadReady;
   logic                             halt;
   logic                             err;
   logic                             wbValid;
   logic [procPkg::regAddrWidth-1:0] wbReg;
   logic [procPkg::dataWidth-1:0]    wbData;

   logic [procPkg::dataWidth-1:0] prog [$];       // Program of the current test
   writeT                         expWrites [$];  // Writes still to retire
   logic                          expErr;         // Model ended on an illegal opcode
   int                            cycleCount = 0;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   proc #(.instrWords(256), .dataWords(256)) dut (
      .clk(clk), .reset(reset), .run(run),
      .loadValid(loadValid), .loadAddr(loadAddr), .loadData(loadData), .loadReady(loadReady),
      .halt(halt), .err(err), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles)  // Hung DUT or testbench
         abortRun($sformatf("Timeout: run did not finish within %0d cycles", timeoutCycles));
   end

   task automatic checkWrite(input logic [procPkg::regAddrWidth-1:0] gotReg,
                             input logic [procPkg::dataWidth-1:0] gotData,
                             input writeT exp, input string what);
      if (gotReg !== exp.r || gotData !== exp.d)
         abortRun($sformatf("FAIL at %0t: %s wrote r%0d=%h, expected r%0d=%h",
                            $time, what, gotReg, gotData, exp.r, exp.d));
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp)
         abortRun($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp));
   endtask

   task automatic resetDut();
      reset <= 1'b1;
      run   <= 1'b0;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);                                    // Outputs settled
      checkFlag("halt after reset", halt, 1'b0);
      checkFlag("err after reset", err, 1'b0);
      checkFlag("wbValid after reset", wbValid, 1'b0);
      checkFlag("loadReady after reset", loadReady, 1'b1);
      @(posedge clk);
   endtask

   // Push every program word through the load handshake
   task automatic loadProgram();
      foreach (prog[i]) begin
         loadValid <= 1'b1;
         loadAddr  <= 16'(i);
         loadData  <= prog[i];
         do @(negedge clk); while (!loadReady);  // Hold until the port is ready
         @(posedge clk);                          // Word taken on this edge
      end
      loadValid <= 1'b0;
   endtask

   `include "procTests.svh"

   initial begin
      void'($urandom(32'h9d21));  // Single seed for the run
      reset     <= 1'b1;
      run       <= 1'b0;
      loadValid <= 1'b0;
      loadAddr  <= '0;
      loadData  <= '0;
      regAluOps();
      immediateOps();
      memoryRoundTrip();
      branchAndJump();
      haltAndTrap();
      loadPortGuard();
      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: hdl/proc.sv
`timescale 1ns/1ns

module proc #(
   parameter int instrWords = 256,                         // Program words
   parameter int dataWords  = 256                          // Data words
) (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             run,           // Start execution
   input  logic                             loadValid,
   input  logic [procPkg::dataWidth-1:0]    loadAddr,
   input  logic [procPkg::dataWidth-1:0]    loadData,
   output logic                             loadReady,
   output logic                             halt,
   output logic                             err,           // Illegal opcode trap
   output logic                             wbValid,       // Register write this cycle
   output logic [procPkg::regAddrWidth-1:0] wbReg,
   output logic [procPkg::dataWidth-1:0]    wbData
);

   logic [procPkg::dataWidth-1:0]    instruction;
   logic                             ctlRegWrite;
   procPkg::regDestT                 ctlRegDest;
   logic [1:0]                       ctlAluSrc;
   procPkg::aluOpT                   ctlAluOp;
   logic [1:0]                       ctlImmSel;
   logic                             ctlMemRead;
   logic                             ctlMemWrite;
   logic                             ctlMemToReg;
   logic                             ctlBranch;
   logic                             ctlBranchNot;
   logic                             ctlJump;
   logic                             ctlHalt;
   logic [procPkg::dataWidth-1:0]    regVal1;
   logic [procPkg::dataWidth-1:0]    regVal2;
   logic [procPkg::dataWidth-1:0]    immExt;
   logic [procPkg::regAddrWidth-1:0] writeReg;
   logic [procPkg::dataWidth-1:0]    aluResult;
   logic                             branchTaken;
   logic [procPkg::dataWidth-1:0]    regWriteData;

   // Trace taps the writeback path directly
   assign wbValid = ctlRegWrite;
   assign wbReg   = writeReg;
   assign wbData  = regWriteData;

   fetch #(.instrWords(instrWords)) fetch0 (
      .clk(clk), .reset(reset), .run(run), .stop(ctlHalt),
      .loadValid(loadValid), .loadAddr(loadAddr), .loadData(loadData), .loadReady(loadReady),
      .branchTaken(branchTaken), .jump(ctlJump), .immExt(immExt), .instruction(instruction));

   control control0 (
      .clk(clk), .reset(reset), .run(run), .instruction(instruction),
      .ctlRegWrite(ctlRegWrite), .ctlRegDest(ctlRegDest), .ctlAluSrc(ctlAluSrc),
      .ctlAluOp(ctlAluOp), .ctlImmSel(ctlImmSel), .ctlMemRead(ctlMemRead),
      .ctlMemWrite(ctlMemWrite), .ctlMemToReg(ctlMemToReg), .ctlBranch(ctlBranch),
      .ctlBranchNot(ctlBranchNot), .ctlJump(ctlJump), .ctlHalt(ctlHalt),
      .halt(halt), .err(err));

   decode decode0 (
      .clk(clk), .reset(reset), .instruction(instruction), .regWrite(ctlRegWrite),
      .regDest(ctlRegDest), .immSel(ctlImmSel), .writeData(regWriteData),
      .regVal1(regVal1), .regVal2(regVal2), .immExt(immExt), .writeReg(writeReg));

   execute execute0 (
      .regVal1(regVal1), .regVal2(regVal2), .immExt(immExt), .aluSrc(ctlAluSrc),
      .aluOp(ctlAluOp), .branch(ctlBranch), .branchNot(ctlBranchNot),
      .aluResult(aluResult), .branchTaken(branchTaken));

   memory #(.dataWords(dataWords)) memory0 (
      .clk(clk), .reset(reset), .aluResult(aluResult), .storeData(regVal2),
      .memRead(ctlMemRead), .memWrite(ctlMemWrite), .memToReg(ctlMemToReg),
      .regWriteData(regWriteData));

endmodule

// File: hdl/memory.sv
`timescale 1ns/1ns

module memory #(
   parameter int dataWords = 256                        // Data memory depth
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [procPkg::dataWidth-1:0] aluResult,     // Address or ALU value
   input  logic [procPkg::dataWidth-1:0] storeData,     // rt value for ST
   input  logic                          memRead,
   input  logic                          memWrite,      // Already gated by control
   input  logic                          memToReg,
   output logic [procPkg::dataWidth-1:0] regWriteData   // Back to the register file
);

   localparam int addrBits = $clog2(dataWords);

   logic [procPkg::dataWidth-1:0] dataMem [dataWords];  // Word addressed
   logic [addrBits-1:0]           addr;
   logic [procPkg::dataWidth-1:0] readData;

   assign addr     = aluResult[addrBits-1:0];       // Upper bits ignored
   assign readData = memRead ? dataMem[addr] : '0;  // Asynchronous read

   // Writeback mux
   assign regWriteData = memToReg ? readData : aluResult;

   always_ff @(posedge clk) begin
      if (memWrite && !reset) begin  // No stores while in reset
         dataMem[addr] <= storeData;
      end
   end

endmodule

// File: hdl/execute.sv
`timescale 1ns/1ns

module execute (
   input  logic [procPkg::dataWidth-1:0] regVal1,      // rs
   input  logic [procPkg::dataWidth-1:0] regVal2,      // rt
   input  logic [procPkg::dataWidth-1:0] immExt,
   input  logic [1:0]                    aluSrc,       // Operand select bits
   input  procPkg::aluOpT                aluOp,
   input  logic                          branch,
   input  logic                          branchNot,    // Invert zero test
   output logic [procPkg::dataWidth-1:0] aluResult,
   output logic                          branchTaken
);

   logic [procPkg::dataWidth-1:0] opA;     // rs side
   logic [procPkg::dataWidth-1:0] opB;     // rt or immediate side
   logic                          isZero;

   // Operand select
   assign opA = aluSrc[procPkg::aluSrcZeroBit] ? '0 : regVal1;      // Zero for LBI
   assign opB = aluSrc[procPkg::aluSrcImmBit] ? immExt : regVal2;

   // ALU, all ops wrap at data width
   always_comb begin
      case (aluOp)
         procPkg::aluAdd: aluResult = opA + opB;
         procPkg::aluSub: aluResult = opB - opA;  // rt - rs or imm - rs
         procPkg::aluAnd: aluResult = opA & opB;
         procPkg::aluXor: aluResult = opA ^ opB;
         default:         aluResult = '0;
      endcase
   end

   // Branch condition on rs
   assign isZero      = (regVal1 == '0);
   assign branchTaken = branch && (isZero != branchNot);  // BEQZ on zero, BNEZ otherwise

endmodule

// File: hdl/decode.sv
`timescale 1ns/1ns

module decode (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [procPkg::dataWidth-1:0]    instruction,
   input  logic                             regWrite,     // Already gated by control
   input  procPkg::regDestT                 regDest,
   input  logic [1:0]                       immSel,
   input  logic [procPkg::dataWidth-1:0]    writeData,    // From writeback mux
   output logic [procPkg::dataWidth-1:0]    regVal1,      // rs value
   output logic [procPkg::dataWidth-1:0]    regVal2,      // rt value
   output logic [procPkg::dataWidth-1:0]    immExt,
   output logic [procPkg::regAddrWidth-1:0] writeReg
);

   localparam int imm5Bits   = procPkg::imm5Hi - procPkg::imm5Lo + 1;
   localparam int imm8Bits   = procPkg::imm8Hi - procPkg::imm8Lo + 1;
   localparam int disp11Bits = procPkg::disp11Hi - procPkg::disp11Lo + 1;

   logic [procPkg::dataWidth-1:0]    regs [procPkg::numRegs];  // General registers
   logic [procPkg::regAddrWidth-1:0] rsIdx;
   logic [procPkg::regAddrWidth-1:0] rtIdx;
   logic [imm5Bits-1:0]              imm5;
   logic [imm8Bits-1:0]              imm8;
   logic [disp11Bits-1:0]            disp11;

   assign rsIdx  = instruction[procPkg::rsHi:procPkg::rsLo];
   assign rtIdx  = instruction[procPkg::rtHi:procPkg::rtLo];
   assign imm5   = instruction[procPkg::imm5Hi:procPkg::imm5Lo];
   assign imm8   = instruction[procPkg::imm8Hi:procPkg::imm8Lo];
   assign disp11 = instruction[procPkg::disp11Hi:procPkg::disp11Lo];

   assign regVal1 = regs[rsIdx];  // Asynchronous read ports
   assign regVal2 = regs[rtIdx];

   // Destination index
   always_comb begin
      case (regDest)
         procPkg::destRt: writeReg = instruction[procPkg::iRdHi:procPkg::iRdLo];
         procPkg::destRd: writeReg = instruction[procPkg::rdHi:procPkg::rdLo];
         procPkg::destRs: writeReg = rsIdx;  // LBI
         default:         writeReg = rtIdx;
      endcase
   end

   // Sign extension to data width
   always_comb begin
      case (immSel)
         procPkg::immSel5:  immExt = {{(procPkg::dataWidth-imm5Bits){imm5[imm5Bits-1]}}, imm5};
         procPkg::immSel8:  immExt = {{(procPkg::dataWidth-imm8Bits){imm8[imm8Bits-1]}}, imm8};
         procPkg::immSel11: immExt = {{(procPkg::dataWidth-disp11Bits){disp11[disp11Bits-1]}},
                                      disp11};
         default:           immExt = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < procPkg::numRegs; i++) begin
            regs[i] <= '0;  // All registers start at zero
         end
      end else if (regWrite) begin
         regs[writeReg] <= writeData;  // Visible next cycle
      end
   end

endmodule

// File: hdl/control.sv
`timescale 1ns/1ns

module control (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          run,
   input  logic [procPkg::dataWidth-1:0] instruction,
   output logic                          ctlRegWrite,   // Gated, doubles as trace valid
   output procPkg::regDestT              ctlRegDest,
   output logic [1:0]                    ctlAluSrc,     // Immediate and zero operand bits
   output procPkg::aluOpT                ctlAluOp,
   output logic [1:0]                    ctlImmSel,
   output logic                          ctlMemRead,
   output logic                          ctlMemWrite,   // Gated
   output logic                          ctlMemToReg,
   output logic                          ctlBranch,
   output logic                          ctlBranchNot,  // BNEZ sense
   output logic                          ctlJump,
   output logic                          ctlHalt,       // Hold the PC
   output logic                          halt,
   output logic                          err
);

   procPkg::opcodeT opcode;
   logic            active;       // Instruction retires this cycle
   logic            decRegWrite;
   logic            decMemWrite;
   logic            decHalt;
   logic            illegal;

   assign opcode = procPkg::opcodeT'(instruction[procPkg::opcodeHi:procPkg::opcodeLo]);
   assign active = run && !halt && !err;

   always_comb begin
      decRegWrite  = 1'b0;  // Defaults describe a NOP
      ctlRegDest   = procPkg::destRt;
      ctlAluSrc    = '0;
      ctlAluOp     = procPkg::aluAdd;
      ctlImmSel    = procPkg::immSel5;
      ctlMemRead   = 1'b0;
      decMemWrite  = 1'b0;
      ctlMemToReg  = 1'b0;
      ctlBranch    = 1'b0;
      ctlBranchNot = 1'b0;
      ctlJump      = 1'b0;
      decHalt      = 1'b0;
      illegal      = 1'b0;
      case (opcode)
         procPkg::opHalt: decHalt = 1'b1;
         procPkg::opNop: begin
            // No state changes
         end
         procPkg::opAlu: begin
            decRegWrite = 1'b1;
            ctlRegDest  = procPkg::destRd;
            ctlAluOp    = procPkg::aluOpT'(instruction[procPkg::funcHi:procPkg::funcLo]);
         end
         procPkg::opAddi, procPkg::opSubi: begin
            decRegWrite                      = 1'b1;
            ctlAluSrc[procPkg::aluSrcImmBit] = 1'b1;
            ctlAluOp = (opcode == procPkg::opSubi) ? procPkg::aluSub : procPkg::aluAdd;
         end
         procPkg::opLbi: begin
            decRegWrite                       = 1'b1;
            ctlRegDest                        = procPkg::destRs;
            ctlImmSel                         = procPkg::immSel8;
            ctlAluSrc[procPkg::aluSrcImmBit]  = 1'b1;  // 0 + imm8
            ctlAluSrc[procPkg::aluSrcZeroBit] = 1'b1;
         end
         procPkg::opLd: begin
            decRegWrite                      = 1'b1;
            ctlAluSrc[procPkg::aluSrcImmBit] = 1'b1;  // Address is rs + imm5
            ctlMemRead                       = 1'b1;
            ctlMemToReg                      = 1'b1;
         end
         procPkg::opSt: begin
            decMemWrite                      = 1'b1;  // Data comes from the rt port
            ctlAluSrc[procPkg::aluSrcImmBit] = 1'b1;
         end
         procPkg::opBeqz, procPkg::opBnez: begin
            ctlBranch    = 1'b1;
            ctlBranchNot = (opcode == procPkg::opBnez);
            ctlImmSel    = procPkg::immSel8;
         end
         procPkg::opJ: begin
            ctlJump   = 1'b1;
            ctlImmSel = procPkg::immSel11;
         end
         default: illegal = 1'b1;  // Unused opcode trap
      endcase
   end

   assign ctlRegWrite = active && decRegWrite;
   assign ctlMemWrite = active && decMemWrite;
   assign ctlHalt     = halt || err || decHalt || illegal;  // PC stays on HALT or trap

   // Sticky status, cleared only by reset
   always_ff @(posedge clk) begin
      if (reset) begin
         halt <= 1'b0;
         err  <= 1'b0;
      end else if (active) begin
         if (decHalt) halt <= 1'b1;
         if (illegal) err <= 1'b1;
      end
   end

endmodule

// File: hdl/fetch.sv
`timescale 1ns/1ns

module fetch #(
   parameter int instrWords = 256                       // Instruction memory depth
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          run,           // Core executing
   input  logic                          stop,          // Halted or trapped
   input  logic                          loadValid,     // Program load request
   input  logic [procPkg::dataWidth-1:0] loadAddr,
   input  logic [procPkg::dataWidth-1:0] loadData,
   output logic                          loadReady,     // Load accepted while idle
   input  logic                          branchTaken,
   input  logic                          jump,
   input  logic [procPkg::dataWidth-1:0] immExt,        // Branch or jump offset
   output logic [procPkg::dataWidth-1:0] instruction
);

   localparam int addrBits = $clog2(instrWords);

   logic [procPkg::dataWidth-1:0] pc;                        // Program counter
   logic [procPkg::dataWidth-1:0] pcPlusOne;
   logic [procPkg::dataWidth-1:0] nextPc;
   logic [procPkg::dataWidth-1:0] instrMem [instrWords];    // Word addressed program store

   assign loadReady   = !run;                                   // Loads only while stopped
   assign pcPlusOne   = pc + procPkg::dataWidth'(1);
   assign nextPc      = (branchTaken || jump) ? pcPlusOne + immExt : pcPlusOne;  // Relative to PC+1
   assign instruction = instrMem[pc[addrBits-1:0]];             // Asynchronous read

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (run && !stop) begin  // Freeze when idle or halted
         pc <= nextPc;
      end
   end

   // Program load port
   always_ff @(posedge clk) begin
      if (loadValid && loadReady) begin
         instrMem[loadAddr[addrBits-1:0]] <= loadData;
      end
   end

endmodule

// File: hdl/procPkg.sv
package procPkg;

   localparam int dataWidth    = 16;                 // Data, instruction and address width
   localparam int regAddrWidth = 3;                  // Register index width
   localparam int numRegs      = 1 << regAddrWidth;  // Eight general registers

   // Primary opcodes, anything not listed traps as illegal
   typedef enum logic [4:0] {
      opHalt = 5'b00000,  // Stop the core
      opNop  = 5'b00001,  // No operation
      opJ    = 5'b00100,  // PC relative jump
      opAddi = 5'b01000,  // rd = rs + imm5
      opSubi = 5'b01001,  // rd = imm5 - rs
      opBeqz = 5'b01100,  // Branch if rs is zero
      opBnez = 5'b01101,  // Branch if rs is nonzero
      opSt   = 5'b10000,  // mem[rs + imm5] = rd
      opLd   = 5'b10001,  // rd = mem[rs + imm5]
      opLbi  = 5'b11000,  // rs = imm8
      opAlu  = 5'b11011   // R-type, func picks the operation
   } opcodeT;

   typedef enum logic [1:0] {
      aluAdd = 2'b00,  // Wrapping add
      aluSub = 2'b01,  // Second operand minus first
      aluAnd = 2'b10,  // Bitwise and
      aluXor = 2'b11   // Bitwise xor
   } aluOpT;

   typedef enum logic [1:0] {
      destRt,  // I-type destination in bits 7:5
      destRd,  // R-type destination in bits 4:2
      destRs   // LBI writes its rs field
   } regDestT;

   // Immediate select codes
   localparam logic [1:0] immSel5  = 2'd0;  // ADDI, SUBI, LD, ST
   localparam logic [1:0] immSel8  = 2'd1;  // LBI and branches
   localparam logic [1:0] immSel11 = 2'd2;  // J

   // ALU operand select bits
   localparam int aluSrcImmBit  = 0;  // Operand B from the immediate
   localparam int aluSrcZeroBit = 1;  // Operand A forced to zero

   // Instruction field positions
   localparam int opcodeHi = 15;
   localparam int opcodeLo = 11;
   localparam int rsHi     = 10;
   localparam int rsLo     = 8;
   localparam int rtHi     = 7;
   localparam int rtLo     = 5;
   localparam int rdHi     = 4;   // R-type destination
   localparam int rdLo     = 2;
   localparam int iRdHi    = 7;   // I-type destination
   localparam int iRdLo    = 5;
   localparam int funcHi   = 1;   // R-type function
   localparam int funcLo   = 0;
   localparam int imm5Hi   = 4;
   localparam int imm5Lo   = 0;
   localparam int imm8Hi   = 7;
   localparam int imm8Lo   = 0;
   localparam int disp11Hi = 10;
   localparam int disp11Lo = 0;

endpackage
